// ==== dv/uart_vectors.txt ====
# op addr data resp rdata, all hex; op W write, R read, I wait until tx is idle
# resp 0 okay, 2 slverr; rdata is checked on reads only
R 8 0 0 2
W 0 55 0 0
W 0 a3 0 0
W 0 0f 0 0
I 0 0 0 0
R 8 0 0 2
W 4 5 0 0
R 4 0 0 5
W 0 3c 0 0
W 0 81 0 0
I 0 0 0 0
W 4 0 0 0
R 4 0 0 1
W 0 e7 0 0
I 0 0 0 0
W 4 10 0 0
R 4 0 0 10
# Burst of eleven bytes, the FIFO plus the serializer hold nine
W 0 01 0 0
W 0 02 0 0
W 0 03 0 0
W 0 04 0 0
W 0 05 0 0
W 0 06 0 0
W 0 07 0 0
W 0 08 0 0
W 0 09 0 0
W 0 0a 2 0
W 0 0b 2 0
R 8 0 0 5
I 0 0 0 0
R 8 0 0 2
# Unmapped, write-only and read-only accesses
W c 1234 2 0
R c 0 2 0
R 0 0 2 0
W 8 ff 2 0

// ==== uart_periph.f ====
+incdir+include
hw/uart_pkg.sv
hw/uart_tx_fifo.sv
hw/uart_tx_serializer.sv
hw/uart_axil_slave.sv
hw/uart_periph.sv
dv/uart_periph_tb.sv

// ==== Makefile ====
# Verilator simulation of the UART peripheral
TOP := uart_periph_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timescale 1ns/1ps -f uart_periph.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/uart_periph_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_periph_tb;

    import uart_pkg::*;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [`AXI_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`AXI_DATA_W-1:0]   rdata;
    axi_resp_e                rresp;
    logic                     rvalid;
    logic                     rready;
    logic [`AXI_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`AXI_DATA_W-1:0]   wdata;
    logic [`AXI_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    axi_resp_e                bresp;
    logic                     bvalid;
    logic                     bready;
    logic                     tx;

    logic [7:0]             vec_op[$];
    logic [`AXI_ADDR_W-1:0] vec_addr[$];
    logic [`AXI_DATA_W-1:0] vec_data[$];
    axi_resp_e              vec_resp[$];
    logic [`AXI_DATA_W-1:0] vec_rdata[$];
    logic [7:0]             exp_q[$];
    logic [7:0]             rx_q[$];

    uart_divisor_t model_div = uart_divisor_t'(`UART_DIV_RESET);
    int            occupancy = 0;
    int            resp_errs = 0;
    int            rdata_errs = 0;
    int            byte_errs = 0;
    int            other_errs = 0;
    int            limit_ns = 0;
    integer        seed = 32'h0768_f82f;

    uart_periph uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .tx      (tx)
    );

    always #5 clk = ~clk;

    task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
        if (got !== exp) begin
            resp_errs++;
            $display("mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_rdata(input logic [`AXI_DATA_W-1:0] got,
                               input logic [`AXI_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            rdata_errs++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            byte_errs++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("errors: resp %0d, rdata %0d, byte %0d, other %0d",
                 resp_errs, rdata_errs, byte_errs, other_errs);
        if (resp_errs + rdata_errs + byte_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic load_vectors();
        int         fd;
        int         code;
        int         c;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic [1:0] rs;
        fd = $fopen("dv/uart_vectors.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open dv/uart_vectors.txt");
            return;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h %h %h", a, d, rs, r);
                if (code != 4) begin
                    other_errs++;
                    $display("malformed line in the vectors file after op %c", op);
                end else begin
                    vec_op.push_back(op);
                    vec_addr.push_back(a);
                    vec_data.push_back(d);
                    vec_resp.push_back(axi_resp_e'(rs));
                    vec_rdata.push_back(r);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             output axi_resp_e resp);
        int stall;
        awaddr  = addr;
        wdata   = data;
        // Strobes are ignored by the slave, so any pattern will do
        wstrb   = 4'($random(seed));
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) begin
            other_errs++;
            $display("no write response one cycle after acceptance at %0d ns", $time);
        end
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) begin
            @(negedge clk);
            if (!bvalid || awready || wready) begin
                other_errs++;
                $display("write response dropped or new write accepted at %0d ns", $time);
            end
        end
        while (!bvalid) @(negedge clk);
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        int stall;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        if (!rvalid) begin
            other_errs++;
            $display("no read response one cycle after acceptance at %0d ns", $time);
        end
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) begin
            @(negedge clk);
            if (!rvalid || arready) begin
                other_errs++;
                $display("read response dropped or new read accepted at %0d ns", $time);
            end
        end
        while (!rvalid) @(negedge clk);
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_line_idle();
        while (rx_q.size() < exp_q.size()) @(negedge clk);
        // Remainder of the last stop bit
        repeat (int'(model_div) + 2) @(negedge clk);
    endtask

    // Decodes frames on tx at mid-bit
    initial begin : line_monitor
        int         div;
        logic [7:0] b;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge tx);
            div = int'(model_div);
            // Offset of 2 ns keeps samples away from both clock edges
            #(div * 5 + 2);
            if (tx !== 1'b0) begin
                other_errs++;
                $display("start bit did not stay low at %0d ns", $time);
            end
            for (int i = 0; i < 8; i++) begin
                #(div * 10);
                b[i] = tx;
            end
            #(div * 10);
            if (tx !== 1'b1) begin
                other_errs++;
                $display("stop bit missing at %0d ns", $time);
            end
            rx_q.push_back(b);
            occupancy--;
        end
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        other_errs++;
        $display("run timed out after %0d ns", limit_ns);
        report_and_finish();
    end

    initial begin : main
        int            div;
        int            total;
        axi_resp_e     got_resp;
        axi_resp_e     predicted;
        logic [31:0]   got_data;
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;

        load_vectors();
        // Ten bits per byte at the divisor in force when it is written
        div   = `UART_DIV_RESET;
        total = 0;
        foreach (vec_op[i]) begin
            if (vec_op[i] == "W" && vec_addr[i] == `UART_REG_TXDATA) begin
                total += 10 * div * 10;
            end else if (vec_op[i] == "W" && vec_addr[i] == `UART_REG_DIVISOR) begin
                div = (vec_data[i][15:0] == 16'd0) ? 1 : int'(vec_data[i][15:0]);
            end
        end
        limit_ns = total + 2000;

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        foreach (vec_op[i]) begin
            case (vec_op[i])
                "W": begin
                    if (vec_addr[i] == `UART_REG_TXDATA) begin
                        predicted = (occupancy >= `UART_FIFO_DEPTH + 1) ? resp_slverr : resp_okay;
                        if (predicted != vec_resp[i]) begin
                            other_errs++;
                            $display("vector %0d disagrees with the occupancy model", i);
                        end
                    end
                    bus_write(vec_addr[i], vec_data[i], got_resp);
                    check_resp(got_resp, vec_resp[i], $sformatf("bresp of vector %0d", i));
                    if (vec_addr[i] == `UART_REG_TXDATA && vec_resp[i] == resp_okay) begin
                        exp_q.push_back(vec_data[i][7:0]);
                        occupancy++;
                    end
                    if (vec_addr[i] == `UART_REG_DIVISOR) begin
                        model_div = (vec_data[i][15:0] == 16'd0) ? uart_divisor_t'(1)
                                                                  : vec_data[i][15:0];
                    end
                end
                "R": begin
                    bus_read(vec_addr[i], got_data, got_resp);
                    check_resp(got_resp, vec_resp[i], $sformatf("rresp of vector %0d", i));
                    check_rdata(got_data, vec_rdata[i], $sformatf("rdata of vector %0d", i));
                end
                "I": begin
                    wait_line_idle();
                end
                default: begin
                    other_errs++;
                    $display("unknown operation in vector %0d", i);
                end
            endcase
        end

        wait_line_idle();
        if (rx_q.size() != exp_q.size()) begin
            other_errs++;
            $display("received %0d bytes on tx but expected %0d", rx_q.size(), exp_q.size());
        end
        for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
            check_byte(rx_q[i], exp_q[i], $sformatf("tx byte %0d", i));
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== hw/uart_periph.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_periph (
    input  logic                     clk,
    input  logic                     rst_n,
    // AR
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    // R
    output logic [`AXI_DATA_W-1:0]   rdata,
    output uart_pkg::axi_resp_e      rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // AW
    input  logic [`AXI_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    // W
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic [`AXI_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    // B
    output uart_pkg::axi_resp_e      bresp,
    output logic                     bvalid,
    input  logic                     bready,
    // Serial line
    output logic                     tx
);

    import uart_pkg::*;

    logic          push;
    logic [7:0]    push_data;
    logic          pop;
    logic [7:0]    head_data;
    logic          fifo_full;
    logic          fifo_empty;
    logic          tx_busy;
    uart_divisor_t divisor;

    uart_axil_slave u_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .tx_busy    (tx_busy),
        .push       (push),
        .push_data  (push_data),
        .divisor    (divisor)
    );

    uart_tx_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (push),
        .wr_data (push_data),
        .pop     (pop),
        .rd_data (head_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    uart_tx_serializer u_ser (
        .clk     (clk),
        .rst_n   (rst_n),
        .empty   (fifo_empty),
        .rd_data (head_data),
        .pop     (pop),
        .divisor (divisor),
        .tx      (tx),
        .busy    (tx_busy)
    );

endmodule

`default_nettype wire

// ==== hw/uart_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_axil_slave (
    input  logic                     clk,
    input  logic                     rst_n,
    // AR
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    // R
    output logic [`AXI_DATA_W-1:0]   rdata,
    output uart_pkg::axi_resp_e      rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // AW
    input  logic [`AXI_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    // W
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic [`AXI_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    // B
    output uart_pkg::axi_resp_e      bresp,
    output logic                     bvalid,
    input  logic                     bready,
    // FIFO and serializer side
    input  logic                     fifo_full,
    input  logic                     fifo_empty,
    input  logic                     tx_busy,
    output logic                     push,
    output logic [7:0]               push_data,
    output uart_pkg::uart_divisor_t  divisor
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        WRESP = 2'b01,
        RRESP = 2'b10
    } state_e;

    state_e       state;
    uart_wword_u  wword;
    uart_wword_u  div_word;
    uart_status_t status;
    logic         wr_go;
    logic         rd_go;
    logic         wr_txdata;
    logic         wr_divisor;
    logic [`AXI_DATA_W-1:0] rd_word;
    logic         rd_err;

    assign awready = (state == IDLE);
    assign wready  = (state == IDLE);
    // Writes win when both channels are offered at once
    assign arready = (state == IDLE) && !(awvalid && wvalid);
    assign bvalid  = (state == WRESP);
    assign rvalid  = (state == RRESP);

    assign wr_go = (state == IDLE) && awvalid && wvalid;
    assign rd_go = arready && arvalid;

    assign wword      = wdata;
    assign wr_txdata  = (awaddr == `UART_REG_TXDATA);
    assign wr_divisor = (awaddr == `UART_REG_DIVISOR);

    // Full FIFO drops the byte
    assign push      = wr_go && wr_txdata && !fifo_full;
    assign push_data = wword.tx.data;

    always_comb begin
        status            = '0;
        status.fifo_full  = fifo_full;
        status.fifo_empty = fifo_empty;
        status.tx_busy    = tx_busy;
        div_word              = '0;
        div_word.ctrl.divisor = divisor;
    end

    // TXDATA is write only, so a read of it is an error like any unmapped one
    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            `UART_REG_DIVISOR: rd_word = div_word;
            `UART_REG_STATUS:  rd_word = status;
            default:           rd_err  = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_go) begin
                        state <= WRESP;
                    end else if (rd_go) begin
                        state <= RRESP;
                    end
                end
                WRESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end
                RRESP: begin
                    if (rready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= (push || wr_divisor) ? resp_okay : resp_slverr;
        end
        if (rd_go) begin
            rdata <= rd_word;
            rresp <= rd_err ? resp_slverr : resp_okay;
        end
    end

    // Zero would stall the baud counter, so it is held at one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            divisor <= uart_divisor_t'(`UART_DIV_RESET);
        end else if (wr_go && wr_divisor) begin
            divisor <= (wword.ctrl.divisor == '0) ? uart_divisor_t'(1) : wword.ctrl.divisor;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    empty,
    input  logic [7:0]              rd_data,
    output logic                    pop,
    input  uart_pkg::uart_divisor_t divisor,
    output logic                    tx,
    output logic                    busy
);

    import uart_pkg::*;

    localparam int FRAME_BITS = 10;

    logic [FRAME_BITS-1:0] frame;
    logic [3:0]            bit_idx;
    uart_divisor_t         baud_cnt;
    uart_divisor_t         div_q;
    logic                  active;
    logic                  bit_done;
    logic                  last_cycle;

    assign bit_done   = active && (baud_cnt == div_q - uart_divisor_t'(1));
    assign last_cycle = bit_done && (bit_idx == 4'(FRAME_BITS - 1));

    // Next byte is taken on the stop bit's final cycle for gapless frames
    assign pop  = (!active || last_cycle) && !empty;
    assign busy = active;

    // Shifted-in ones keep the line high once a frame ends
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            frame    <= '1;
            bit_idx  <= '0;
            baud_cnt <= '0;
        end else if (pop) begin
            active   <= 1'b1;
            // Stop, data LSB first, start
            frame    <= {1'b1, rd_data, 1'b0};
            bit_idx  <= '0;
            baud_cnt <= '0;
        end else if (active) begin
            if (bit_done) begin
                baud_cnt <= '0;
                if (last_cycle) begin
                    active <= 1'b0;
                end else begin
                    frame   <= {1'b1, frame[FRAME_BITS-1:1]};
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // Divisor is held for the whole frame
    always_ff @(posedge clk) begin
        if (pop) begin
            div_q <= divisor;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_tx_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] wr_data,
    input  logic       pop,
    output logic [7:0] rd_data,
    output logic       full,
    output logic       empty
);

    import uart_pkg::*;

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    uart_fifo_entry_t mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr].data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr].data <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none
`include "uart_settings.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // Clock cycles per serial bit
    typedef logic [15:0] uart_divisor_t;

    // One written word, decoded as a transmit byte or as a new divisor
    typedef union packed {
        struct packed {
            logic [`AXI_DATA_W-9:0] rsvd;
            logic [7:0]             data;
        } tx;
        struct packed {
            logic [`AXI_DATA_W-17:0] rsvd;
            uart_divisor_t           divisor;
        } ctrl;
    } uart_wword_u;

    // STATUS register layout, tx_busy in bit 0
    typedef struct packed {
        logic [`AXI_DATA_W-4:0] rsvd;
        logic                   fifo_full;
        logic                   fifo_empty;
        logic                   tx_busy;
    } uart_status_t;

    typedef struct packed {
        logic [7:0] data;
    } uart_fifo_entry_t;

endpackage

`default_nettype wire

// ==== include/uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// AXI-lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// Transmit FIFO entries
`define UART_FIFO_DEPTH 8

// Clock cycles per serial bit out of reset
`define UART_DIV_RESET 16

// Register byte offsets
`define UART_REG_TXDATA  32'h0000_0000
`define UART_REG_DIVISOR 32'h0000_0004
`define UART_REG_STATUS  32'h0000_0008

`endif
